// File: fetch_buffer.sv
/* First-word-fall-through instruction queue holding word, PC and predecode flags */

`include "fetch_defs.svh"

module fetch_buffer
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  push_i,
    input  logic  pop_i,
    input  logic  clear_i,

    input  word_t wdata_i,
    input  addr_t wpc_i,
    input  pdec_t wpdec_i,

    output logic  empty_o,
    output logic  full_o,
    output word_t rdata_o,
    output addr_t rpc_o,
    output pdec_t rpdec_o
);

    localparam int PTR_W = $clog2(`FETCH_DEPTH);
    localparam int LAST  = `FETCH_DEPTH - 1;

    // Entry storage
    word_t mem_word_q [`FETCH_DEPTH];
    addr_t mem_pc_q   [`FETCH_DEPTH];
    pdec_t mem_pdec_q [`FETCH_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    cnt_t             count_q;

    logic do_push;
    logic do_pop;

    // Wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LAST)) ? '0 : ptr + 1'b1;
    endfunction

    // Clear beats push, pop only when something is there
    assign do_push = push_i && !clear_i;
    assign do_pop  = pop_i && !empty_o && !clear_i;

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 3'd1;
                2'b01:   count_q <= count_q - 3'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_word_q[wr_ptr_q] <= wdata_i;
            mem_pc_q[wr_ptr_q]   <= wpc_i;
            mem_pdec_q[wr_ptr_q] <= wpdec_i;
        end
    end

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == cnt_t'(`FETCH_DEPTH));

    // Head entry falls through, a bubble shows when empty
    assign rdata_o = empty_o ? word_t'(`FETCH_NOP) : mem_word_q[rd_ptr_q];
    assign rpc_o   = empty_o ? '0 : mem_pc_q[rd_ptr_q];
    assign rpdec_o = empty_o ? '0 : mem_pdec_q[rd_ptr_q];

endmodule : fetch_buffer

// File: fetch_ctrl.sv
/* Fetch control FSM with memory and decode credit counters,
   outstanding request count and the stale response drop count */

`include "fetch_defs.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,

    input  logic halt_i,
    input  logic redirect_i,
    input  logic rsp_valid_i,
    input  logic dec_credit_i,
    input  logic buf_empty_i,

    output logic req_valid_o,
    output logic issue_o,
    output logic accept_o,
    output logic pop_o,
    output logic instr_valid_o
);

    fetch_state_e state_q, state_d;

    cnt_t buf_cred_q, buf_cred_d;   // Free queue slots not yet claimed by a request
    cnt_t dec_cred_q, dec_cred_d;   // Words decode can still take
    cnt_t out_cnt_q, out_cnt_d;     // Requests sent, response not yet seen
    cnt_t drop_cnt_q, drop_cnt_d;   // Responses that belong to a dead path
    cnt_t out_left;

    logic issue;
    logic accept;
    logic drop;
    logic instr_valid;

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Single cycle after reset before fetching
            ST_BOOT: state_d = ST_RUN;
            ST_RUN: begin
                if (halt_i) state_d = ST_HALT;
            end
            ST_HALT: begin
                if (!halt_i) state_d = ST_RUN;
            end
            default: state_d = ST_BOOT;
        endcase
    end

    ////////////////////////////////////////
    // Handshake decisions
    ////////////////////////////////////////

    // Never fetch while halting or while the PC reloads
    assign issue = (state_q == ST_RUN) && !halt_i && (buf_cred_q != '0) && !redirect_i;

    // A response in a redirect cycle belongs to the old path and is dropped
    assign accept = rsp_valid_i && (drop_cnt_q == '0) && !redirect_i;
    assign drop   = rsp_valid_i && !accept;

    // Transfer to decode doubles as the queue pop
    assign instr_valid = !buf_empty_i && (dec_cred_q != '0) && !redirect_i;

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    // Outstanding count once this cycle's response is retired
    assign out_left = out_cnt_q - cnt_t'(rsp_valid_i);

    always_comb begin
        out_cnt_d  = out_left + cnt_t'(issue);
        dec_cred_d = dec_cred_q - cnt_t'(instr_valid) + cnt_t'(dec_credit_i);
        if (redirect_i) begin
            // Queue is flushed so only in-flight requests still hold slots
            buf_cred_d = cnt_t'(`FETCH_DEPTH) - out_left;
            drop_cnt_d = out_left;
        end else begin
            buf_cred_d = buf_cred_q - cnt_t'(issue) + cnt_t'(instr_valid) + cnt_t'(drop);
            drop_cnt_d = drop_cnt_q - cnt_t'(drop);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_BOOT;
            buf_cred_q <= cnt_t'(`FETCH_DEPTH);
            dec_cred_q <= cnt_t'(`FETCH_DEC_CREDITS);
            out_cnt_q  <= '0;
            drop_cnt_q <= '0;
        end else begin
            state_q    <= state_d;
            buf_cred_q <= buf_cred_d;
            dec_cred_q <= dec_cred_d;
            out_cnt_q  <= out_cnt_d;
            drop_cnt_q <= drop_cnt_d;
        end
    end

    assign req_valid_o   = issue;
    assign issue_o       = issue;
    assign accept_o      = accept;
    assign pop_o         = instr_valid;
    assign instr_valid_o = instr_valid;

endmodule : fetch_ctrl

// File: fetch_defs.svh
/* Fetch unit constants: reset vector, queue depth, decode credits, NOP encoding */

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////
// Boot
////////////////////////////////////////

// First fetch address after reset
`define FETCH_RESET_VECTOR 32'h0000_1000

////////////////////////////////////////
// Flow control
////////////////////////////////////////

// Instruction queue entries, also the initial memory-side credit count
`define FETCH_DEPTH 4

// Credits decode grants at reset
`define FETCH_DEC_CREDITS 2

////////////////////////////////////////
// Encodings
////////////////////////////////////////

// addi x0,x0,0
`define FETCH_NOP 32'h0000_0013

`endif

// File: fetch_pc_gen.sv
/* Request and response program counters with redirect load */

`include "fetch_defs.svh"

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  issue_i,
    input  logic  accept_i,
    input  logic  redirect_i,
    input  addr_t redirect_target_i,

    output addr_t req_addr_o,
    output addr_t rsp_pc_o
);

    // Address of the next request sent to memory
    addr_t req_pc_q;
    // Address tied to the next in-order response
    addr_t rsp_pc_q;

    // Request side
    // Redirect wins over the sequential step
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_pc_q <= `FETCH_RESET_VECTOR;
        end else if (redirect_i) begin
            req_pc_q <= redirect_target_i;
        end else if (issue_i) begin
            req_pc_q <= req_pc_q + 32'd4;
        end
    end

    // Response side
    // Trails the request PC by the number of outstanding fetches
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_pc_q <= `FETCH_RESET_VECTOR;
        end else if (redirect_i) begin
            rsp_pc_q <= redirect_target_i;
        end else if (accept_i) begin
            rsp_pc_q <= rsp_pc_q + 32'd4;
        end
    end

    assign req_addr_o = req_pc_q;
    assign rsp_pc_o   = rsp_pc_q;

endmodule : fetch_pc_gen

// File: fetch_pkg.sv
/* Fetch unit types: address, word, count, predecode flags, control states */

package fetch_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] word_t;

    // Credit or occupancy count, covers 0 up to the queue depth
    typedef logic [2:0] cnt_t;

    // Predecode flags
    // Bit 1 marks a control transfer, bit 0 an illegal encoding
    typedef logic [1:0] pdec_t;

    // Fetch control states
    typedef enum logic [1:0] {
        ST_BOOT = 2'd0,
        ST_RUN  = 2'd1,
        ST_HALT = 2'd2
    } fetch_state_e;

endpackage : fetch_pkg

// File: fetch_predecode.sv
/* Predecoder marking control transfers and illegal encodings */

module fetch_predecode
    import fetch_pkg::*;
(
    input  word_t rsp_data_i,
    output pdec_t pdec_o
);

    // Major opcodes, bits 6:2 of the RV32IM base set
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

    logic       len32;
    logic       known_major;
    logic       cf_major;
    logic [4:0] major;

    // Low two bits must be 11 for a 32-bit encoding
    assign len32 = (rsp_data_i[1:0] == 2'b11);
    assign major = rsp_data_i[6:2];

    always_comb begin
        known_major = 1'b0;
        cf_major    = 1'b0;
        case (major)
            OPC_LOAD, OPC_MISC_MEM, OPC_OP_IMM, OPC_AUIPC,
            OPC_STORE, OPC_OP, OPC_LUI, OPC_SYSTEM: known_major = 1'b1;
            // Branches and jumps, let decode start redirect work early
            OPC_BRANCH, OPC_JALR, OPC_JAL: begin
                known_major = 1'b1;
                cf_major    = 1'b1;
            end
            default: known_major = 1'b0;
        endcase
    end

    // A short encoding is never a valid control transfer
    assign pdec_o = {cf_major & len32, ~len32 | ~known_major};

endmodule : fetch_predecode

// File: fetch_unit.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_predecode.sv
fetch_ctrl.sv
fetch_buffer.sv
fetch_unit.sv
fetch_unit_assert.sv
tb_fetch_unit.sv

// File: fetch_unit.sv
/* Fetch unit top: control, PC generator, predecoder and instruction queue */

module fetch_unit
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    // Pipeline control
    input  logic  halt_i,
    input  logic  redirect_i,
    input  addr_t redirect_target_i,

    // Instruction memory, credit based
    output logic  req_valid_o,
    output addr_t req_addr_o,
    input  logic  rsp_valid_i,
    input  word_t rsp_data_i,

    // Decode, credit based
    output logic  instr_valid_o,
    output word_t instr_o,
    output addr_t instr_pc_o,
    output pdec_t instr_pdec_o,
    input  logic  dec_credit_i
);

    logic  issue;
    logic  accept;
    logic  pop;
    logic  buf_empty;
    addr_t rsp_pc;
    pdec_t rsp_pdec;

    fetch_ctrl i_fetch_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .halt_i        (halt_i),
        .redirect_i    (redirect_i),
        .rsp_valid_i   (rsp_valid_i),
        .dec_credit_i  (dec_credit_i),
        .buf_empty_i   (buf_empty),
        .req_valid_o   (req_valid_o),
        .issue_o       (issue),
        .accept_o      (accept),
        .pop_o         (pop),
        .instr_valid_o (instr_valid_o)
    );

    fetch_pc_gen i_fetch_pc_gen (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .issue_i           (issue),
        .accept_i          (accept),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .req_addr_o        (req_addr_o),
        .rsp_pc_o          (rsp_pc)
    );

    // Flags computed on the raw response, stored beside the word
    fetch_predecode i_fetch_predecode (
        .rsp_data_i (rsp_data_i),
        .pdec_o     (rsp_pdec)
    );

    // Full flag stays open, memory-side credits already bound the occupancy
    fetch_buffer i_fetch_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (accept),
        .pop_i   (pop),
        .clear_i (redirect_i),
        .wdata_i (rsp_data_i),
        .wpc_i   (rsp_pc),
        .wpdec_i (rsp_pdec),
        .empty_o (buf_empty),
        .full_o  (),
        .rdata_o (instr_o),
        .rpc_o   (instr_pc_o),
        .rpdec_o (instr_pdec_o)
    );

endmodule : fetch_unit

// File: fetch_unit_assert.sv
/* Bound protocol assertions for the fetch unit: request gating,
   quiet cycle after a redirect and the memory-side occupancy bound */

`include "fetch_defs.svh"

module fetch_unit_assert
    import fetch_pkg::*;
(
    input logic         clk_i,
    input logic         rst_ni,
    input logic         redirect_i,
    input logic         req_valid_i,
    input logic         instr_valid_i,
    input fetch_state_e state_i,
    input cnt_t         out_cnt_i,
    input cnt_t         occupancy_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_errors = 0;

    // One bit wider so the sum cannot wrap
    logic [3:0] in_use;
    assign in_use = {1'b0, out_cnt_i} + {1'b0, occupancy_i};

    a_no_req_on_redirect: assert property (
        @(posedge clk_i) disable iff (!rst_ni) redirect_i |-> !req_valid_i
    ) else begin
        assert_errors++;
        $error("request issued in a redirect cycle");
    end

    a_no_req_in_halt: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (state_i == ST_HALT) |-> !req_valid_i
    ) else begin
        assert_errors++;
        $error("request issued in the halt state");
    end

    // Queue was just flushed, nothing can be delivered yet
    a_quiet_after_redirect: assert property (
        @(posedge clk_i) disable iff (!rst_ni) redirect_i |=> !instr_valid_i
    ) else begin
        assert_errors++;
        $error("word delivered in the cycle after a redirect");
    end

    a_occupancy_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni) in_use <= 4'(`FETCH_DEPTH)
    ) else begin
        assert_errors++;
        $error("outstanding requests plus queue entries exceed the depth");
    end

endmodule : fetch_unit_assert

bind fetch_unit fetch_unit_assert i_fetch_unit_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .req_valid_i   (req_valid_o),
    .instr_valid_i (instr_valid_o),
    .state_i       (i_fetch_ctrl.state_q),
    .out_cnt_i     (i_fetch_ctrl.out_cnt_q),
    .occupancy_i   (i_fetch_buffer.count_q)
);

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=Vtb_fetch_unit
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_unit.f \
    --top-module tb_fetch_unit \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// File: tb_fetch_unit.sv
/* Fetch unit testbench with memory and decode credit models,
   reference word and predecode functions, compare process and watchdog */

`include "fetch_defs.svh"

module tb_fetch_unit
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int N_XFER         = 400;
    // Generous bound per transfer, covers halts and redirect refills
    localparam int TIMEOUT_CYCLES = N_XFER * 40;

    logic  clk_i;
    logic  rst_ni;
    logic  halt_i;
    logic  redirect_i;
    addr_t redirect_target_i;
    logic  req_valid_o;
    addr_t req_addr_o;
    logic  rsp_valid_i;
    word_t rsp_data_i;
    logic  instr_valid_o;
    word_t instr_o;
    addr_t instr_pc_o;
    pdec_t instr_pdec_o;
    logic  dec_credit_i;

    integer      seed;
    int unsigned cycle;
    int unsigned errors;
    int unsigned checks;
    int unsigned xfers;
    int unsigned redirects;
    int unsigned halt_left;
    int unsigned dec_held;
    logic        seen_req;
    addr_t       exp_pc;

    // Memory model, requests in order with the cycle each answer is due
    addr_t       mem_addr_q [$];
    int unsigned mem_due_q [$];
    // Decode model, cycles at which held words give their credit back
    int unsigned credit_due_q [$];

    fetch_unit i_fetch_unit (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .halt_i            (halt_i),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .req_valid_o       (req_valid_o),
        .req_addr_o        (req_addr_o),
        .rsp_valid_i       (rsp_valid_i),
        .rsp_data_i        (rsp_data_i),
        .instr_valid_o     (instr_valid_o),
        .instr_o           (instr_o),
        .instr_pc_o        (instr_pc_o),
        .instr_pdec_o      (instr_pdec_o),
        .dec_credit_i      (dec_credit_i)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Word content is a fixed hash of the address
    // Every eighth word gets a 16-bit length code, every fifth is a JAL
    function automatic word_t ref_word(input addr_t addr);
        word_t       mix;
        logic [29:0] idx;
        idx = addr[31:2];
        mix = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h3C5A_A5C3;
        if (idx[2:0] == 3'd7) begin
            return {mix[31:2], 2'b01};
        end else if ((idx % 30'd5) == 30'd0) begin
            return {mix[31:7], 7'b110_1111};
        end
        return {mix[31:2], 2'b11};
    endfunction

    // Flags from the full 7-bit opcode of the RV32IM base set
    function automatic pdec_t ref_pdec(input word_t word);
        logic ctrl;
        logic legal;
        ctrl  = 1'b0;
        legal = 1'b1;
        case (word[6:0])
            // BRANCH, JALR, JAL
            7'b110_0011, 7'b110_0111, 7'b110_1111: ctrl = 1'b1;
            7'b000_0011, 7'b000_1111, 7'b001_0011, 7'b001_0111,
            7'b010_0011, 7'b011_0011, 7'b011_0111, 7'b111_0011: legal = 1'b1;
            default: legal = 1'b0;
        endcase
        return {ctrl, ~legal};
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // Sampling at the rising edge
    ////////////////////////////////////////

    // Requests seen by the memory, outstanding bound and halt gating
    task automatic sample_memory();
        int unsigned delay;
        if (req_valid_o) begin
            if (!seen_req && req_addr_o !== `FETCH_RESET_VECTOR) begin
                report_mismatch("first req_addr_o", req_addr_o, `FETCH_RESET_VECTOR);
            end
            seen_req = 1'b1;
            if (halt_i) report_problem("request issued while halt_i is high");
            delay = 1 + rand_below(4);
            mem_addr_q.push_back(req_addr_o);
            mem_due_q.push_back(cycle + delay - 1);
        end
        if (mem_addr_q.size() > `FETCH_DEPTH) begin
            report_problem("more requests outstanding than buffer entries");
        end
    endtask

    // Compare delivered words against the expected sequence
    task automatic check_transfer();
        word_t exp_word;
        pdec_t exp_pdec;
        if (dec_credit_i) dec_held--;
        if (redirect_i) begin
            exp_pc = redirect_target_i;
            redirects++;
        end
        if (instr_valid_o) begin
            if (redirect_i) report_problem("word delivered in a redirect cycle");
            exp_word = ref_word(exp_pc);
            exp_pdec = ref_pdec(exp_word);
            checks++;
            if (instr_pc_o !== exp_pc) begin
                report_mismatch("instr_pc_o", instr_pc_o, exp_pc);
            end
            if (instr_o !== exp_word) begin
                report_mismatch("instr_o", instr_o, exp_word);
            end
            if (instr_pdec_o !== exp_pdec) begin
                report_mismatch("instr_pdec_o", 32'(instr_pdec_o), 32'(exp_pdec));
            end
            exp_pc = exp_pc + 32'd4;
            xfers++;
            dec_held++;
            credit_due_q.push_back(cycle + rand_below(4));
        end
        if (dec_held > `FETCH_DEC_CREDITS) begin
            report_problem("decode holds more words than it has credits");
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if (req_valid_o || instr_valid_o) begin
                report_problem("valid output raised during reset");
            end
        end else begin
            cycle++;
            sample_memory();
            check_transfer();
        end
    end

    ////////////////////////////////////////
    // Driving at the falling edge
    ////////////////////////////////////////

    // Oldest request answers once its delay ran out, one per cycle
    task automatic drive_memory();
        rsp_valid_i = 1'b0;
        rsp_data_i  = '0;
        if (mem_addr_q.size() > 0 && mem_due_q[0] <= cycle) begin
            rsp_valid_i = 1'b1;
            rsp_data_i  = ref_word(mem_addr_q.pop_front());
            void'(mem_due_q.pop_front());
        end
    endtask

    task automatic return_credit();
        dec_credit_i = 1'b0;
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
            dec_credit_i = 1'b1;
            void'(credit_due_q.pop_front());
        end
    endtask

    // Halt windows, with a redirect forced inside each one
    task automatic drive_controls();
        redirect_i = 1'b0;
        if (halt_left != 0) begin
            halt_i = 1'b1;
            halt_left--;
        end else begin
            halt_i = 1'b0;
            if (xfers > 8 && rand_below(40) == 0) halt_left = 4 + rand_below(16);
        end
        // First stretch runs straight from the reset vector
        if ((xfers >= 16 && rand_below(24) == 0) || (halt_i && halt_left == 2)) begin
            redirect_i        = 1'b1;
            redirect_target_i = addr_t'($random(seed)) & 32'hFFFF_FFFC;
        end
    endtask

    initial begin
        int unsigned total;
        seed              = 76461;
        cycle             = 0;
        errors            = 0;
        checks            = 0;
        xfers             = 0;
        redirects         = 0;
        halt_left         = 0;
        dec_held          = 0;
        seen_req          = 1'b0;
        exp_pc            = `FETCH_RESET_VECTOR;
        rst_ni            = 1'b0;
        halt_i            = 1'b0;
        redirect_i        = 1'b0;
        redirect_target_i = '0;
        rsp_valid_i       = 1'b0;
        rsp_data_i        = '0;
        dec_credit_i      = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        while (xfers < N_XFER) begin
            @(negedge clk_i);
            drive_memory();
            return_credit();
            drive_controls();
        end
        total = errors + i_fetch_unit.i_fetch_unit_assert.assert_errors;
        $display("Checks %0d, transfers %0d, redirects %0d, errors %0d, assertion errors %0d",
                 checks, xfers, redirects, errors,
                 i_fetch_unit.i_fetch_unit_assert.assert_errors);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: only %0d of %0d words delivered after %0d cycles",
                 xfers, N_XFER, TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule : tb_fetch_unit
